/* Makefile */
SIM      = verilator
SIMFLAGS = --binary --timing --assert -Wno-fatal
TOP      = video_out_tb
FILELIST = tb.f

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

/* design/audio_level.sv */
// Audio level control
`timescale 1ns/1ps

module audio_level (
  input  logic                 clk32_i,
  input  logic                 rst_n,
  input  video_pkg::stereo18_t audio_in,
  input  logic [1:0]           volume,
  output video_pkg::stereo16_t audio_out
);

  video_pkg::stereo16_t reduced;

  // volume as a signed shift, 0 mutes
  function automatic logic signed [15:0] vol_scale(input logic signed [15:0] s,
                                                   input logic [1:0]         vol);
    case (vol)
      2'd0:    vol_scale = '0;
      2'd1:    vol_scale = s >>> 2;
      2'd2:    vol_scale = s >>> 1;
      default: vol_scale = s;
    endcase
  endfunction

  // stage 1 drops two low bits, stage 2 scales
  always_ff @(posedge clk32_i or negedge rst_n) begin
    if (!rst_n) begin
      reduced   <= '0;
      audio_out <= '0;
    end else begin
      reduced.left    <= audio_in.left[17:2];
      reduced.right   <= audio_in.right[17:2];
      audio_out.left  <= vol_scale(reduced.left, volume);
      audio_out.right <= vol_scale(reduced.right, volume);
    end
  end

endmodule

/* design/cfg_pkg.sv */
// Configuration bus and register types
package cfg_pkg;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // register map
  parameter logic [3:0] ADDR_VIDEO_CTRL = 4'h0;
  parameter logic [3:0] ADDR_AUDIO_CTRL = 4'h4;
  parameter logic [3:0] ADDR_STATUS     = 4'h8;

  // scanlines 0 none, 1 light, 2 half, 3 dark
  typedef struct packed {
    logic [28:0] reserved;
    logic        wide;
    logic [1:0]  scanlines;
  } video_ctrl_t;

  typedef struct packed {
    logic [29:0] reserved;
    logic [1:0]  volume;
  } audio_ctrl_t;

  // same data word, meaning depends on the address
  typedef union packed {
    video_ctrl_t video;
    audio_ctrl_t audio;
  } ctrl_word_u;

  // settings handed to the datapath
  typedef struct packed {
    logic [1:0] scanlines;
    logic       wide;
    logic [1:0] volume;
  } av_cfg_t;

endpackage

/* design/line_doubler.sv */
// Scan line doubler
`timescale 1ns/1ps

module line_doubler #(
  parameter int LINE_PIXELS = 64
) (
  input  logic              clk32_i,
  input  logic              rst_n,
  input  video_pkg::sync_t  sync_in,
  input  video_pkg::rgb4_t  pix_in,
  input  video_pkg::vmode_e mode,
  input  logic [1:0]        scanlines,
  output video_pkg::rgb6_t  pix_out,
  output logic              out_valid
);

  localparam int IDX_W = $clog2(LINE_PIXELS);
  localparam int CNT_W = $clog2(LINE_PIXELS + 1);
  localparam logic [CNT_W-1:0] LINE_MAX = CNT_W'(LINE_PIXELS);

  // ping-pong line buffers, wr_sel is being filled
  video_pkg::rgb4_t line_buf [2][LINE_PIXELS];

  logic             hs_prev;
  logic             hs_fall;
  logic             bypass;
  logic             wr_sel;
  logic             wr_en;
  logic [CNT_W-1:0] wr_cnt;
  logic [CNT_W-1:0] rd_len;
  logic [CNT_W-1:0] rd_idx;
  logic             rd_pass;
  logic             rd_active;
  video_pkg::rgb4_t rd_pix;

  // top bits repeated into the new low bits
  function automatic video_pkg::rgb6_t expand(input video_pkg::rgb4_t p);
    video_pkg::rgb6_t e;
    e.r = {p.r, p.r[3:2]};
    e.g = {p.g, p.g[3:2]};
    e.b = {p.b, p.b[3:2]};
    return e;
  endfunction

  function automatic logic [5:0] dim_chan(input logic [5:0] v, input logic [1:0] level);
    case (level)
      2'd1:    dim_chan = v - {2'b00, v[5:2]};
      2'd2:    dim_chan = {1'b0, v[5:1]};
      2'd3:    dim_chan = {2'b00, v[5:2]};
      default: dim_chan = v;
    endcase
  endfunction

  function automatic video_pkg::rgb6_t dim(input video_pkg::rgb6_t p, input logic [1:0] level);
    video_pkg::rgb6_t d;
    d.r = dim_chan(p.r, level);
    d.g = dim_chan(p.g, level);
    d.b = dim_chan(p.b, level);
    return d;
  endfunction

  assign hs_fall = hs_prev & ~sync_in.hs_n;
  assign bypass  = (mode == video_pkg::VMODE_MONO);
  // pixels past the buffer end are dropped
  assign wr_en   = sync_in.de & ~hs_fall & (wr_cnt != LINE_MAX);
  assign rd_pix  = line_buf[~wr_sel][rd_idx[IDX_W-1:0]];

  always_ff @(posedge clk32_i) begin
    if (wr_en) begin
      line_buf[wr_sel][wr_cnt[IDX_W-1:0]] <= pix_in;
    end
  end

  // line end swaps banks and starts two read passes
  always_ff @(posedge clk32_i or negedge rst_n) begin
    if (!rst_n) begin
      hs_prev   <= 1'b1;
      wr_sel    <= 1'b0;
      wr_cnt    <= '0;
      rd_len    <= '0;
      rd_idx    <= '0;
      rd_pass   <= 1'b0;
      rd_active <= 1'b0;
    end else begin
      hs_prev <= sync_in.hs_n;
      if (hs_fall) begin
        wr_sel    <= ~wr_sel;
        wr_cnt    <= '0;
        rd_len    <= wr_cnt;
        rd_idx    <= '0;
        rd_pass   <= 1'b0;
        rd_active <= (wr_cnt != '0);
      end else begin
        if (wr_en) begin
          wr_cnt <= wr_cnt + 1'b1;
        end
        if (rd_active) begin
          if (rd_idx == rd_len - 1'b1) begin
            rd_idx  <= '0;
            rd_pass <= 1'b1;
            if (rd_pass) begin
              rd_active <= 1'b0;
            end
          end else begin
            rd_idx <= rd_idx + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk32_i or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= bypass ? sync_in.de : rd_active;
    end
  end

  // second pass is the dimmed copy
  always_ff @(posedge clk32_i) begin
    if (bypass) begin
      pix_out <= expand(pix_in);
    end else begin
      pix_out <= dim(expand(rd_pix), rd_pass ? scanlines : 2'd0);
    end
  end

endmodule

/* design/video_cfg_regs.sv */
// Video and audio settings registers
`timescale 1ns/1ps

module video_cfg_regs (
  input  logic              clk32_i,
  input  logic              rst_n,
  input  cfg_pkg::apb_req_t apb_req,
  output cfg_pkg::apb_rsp_t apb_rsp,
  input  video_pkg::vmode_e mode,
  output cfg_pkg::av_cfg_t  cfg
);

  cfg_pkg::ctrl_word_u wr_word;
  cfg_pkg::ctrl_word_u rd_word;
  logic                access;
  logic                addr_ok;

  // second phase of a transfer
  assign access  = apb_req.psel & apb_req.penable;
  assign wr_word = apb_req.pwdata;

  // address decode and read mux
  always_comb begin
    addr_ok = 1'b1;
    rd_word = '0;
    case (apb_req.paddr)
      cfg_pkg::ADDR_VIDEO_CTRL: begin
        rd_word.video.scanlines = cfg.scanlines;
        rd_word.video.wide      = cfg.wide;
      end
      cfg_pkg::ADDR_AUDIO_CTRL: begin
        rd_word.audio.volume = cfg.volume;
      end
      cfg_pkg::ADDR_STATUS: begin
        rd_word = {30'd0, mode};
      end
      default: begin
        addr_ok = 1'b0;
      end
    endcase
  end

  // no wait states
  always_comb begin
    apb_rsp.prdata  = access ? rd_word : '0;
    apb_rsp.pready  = access;
    apb_rsp.pslverr = access & ~addr_ok;
  end

  // status is read only, writes there are dropped
  always_ff @(posedge clk32_i or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= '0;
    end else if (access && apb_req.pwrite) begin
      case (apb_req.paddr)
        cfg_pkg::ADDR_VIDEO_CTRL: begin
          cfg.scanlines <= wr_word.video.scanlines;
          cfg.wide      <= wr_word.video.wide;
        end
        cfg_pkg::ADDR_AUDIO_CTRL: begin
          cfg.volume <= wr_word.audio.volume;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

/* design/video_mode_detect.sv */
// Video mode detection
`timescale 1ns/1ps

module video_mode_detect #(
  parameter int MONO_LINE_MAX = 1200,
  parameter int PAL_LINES_MIN = 288
) (
  input  logic              clk32_i,
  input  logic              rst_n,
  input  video_pkg::sync_t  sync_in,
  output video_pkg::vmode_e mode,
  output logic              vreset
);

  // counters saturate above their thresholds
  localparam int PERIOD_W = $clog2(MONO_LINE_MAX + 1) + 1;
  localparam int LINES_W  = $clog2(PAL_LINES_MIN + 1) + 1;
  localparam logic [PERIOD_W-1:0] MONO_MAX = PERIOD_W'(MONO_LINE_MAX);
  localparam logic [LINES_W-1:0]  PAL_MIN  = LINES_W'(PAL_LINES_MIN);

  logic                hs_prev;
  logic                vs_prev;
  logic                hs_fall;
  logic                vs_fall;
  logic [PERIOD_W-1:0] period_cnt;
  logic [PERIOD_W-1:0] line_period;
  logic [PERIOD_W-1:0] cur_period;
  logic [LINES_W-1:0]  line_cnt;
  video_pkg::vmode_e   next_mode;

  assign hs_fall = hs_prev & ~sync_in.hs_n;
  assign vs_fall = vs_prev & ~sync_in.vs_n;

  // a line may close on the same clock as the frame
  assign cur_period = hs_fall ? period_cnt : line_period;

  always_comb begin
    if (cur_period <= MONO_MAX) begin
      next_mode = video_pkg::VMODE_MONO;
    end else if (line_cnt >= PAL_MIN) begin
      next_mode = video_pkg::VMODE_PAL;
    end else begin
      next_mode = video_pkg::VMODE_NTSC;
    end
  end

  always_ff @(posedge clk32_i or negedge rst_n) begin
    if (!rst_n) begin
      hs_prev     <= 1'b1;
      vs_prev     <= 1'b1;
      period_cnt  <= '0;
      line_period <= '1;
      line_cnt    <= '0;
      mode        <= video_pkg::VMODE_PAL;
      vreset      <= 1'b0;
    end else begin
      hs_prev <= sync_in.hs_n;
      vs_prev <= sync_in.vs_n;
      vreset  <= vs_fall;
      // edge clock counts as first clock of the new line
      if (hs_fall) begin
        line_period <= period_cnt;
        period_cnt  <= PERIOD_W'(1);
      end else if (period_cnt != '1) begin
        period_cnt <= period_cnt + 1'b1;
      end
      if (vs_fall) begin
        mode     <= next_mode;
        line_cnt <= '0;
      end else if (hs_fall && line_cnt != '1) begin
        line_cnt <= line_cnt + 1'b1;
      end
    end
  end

endmodule

/* design/video_out.sv */
// Video and audio conditioning top
`timescale 1ns/1ps

module video_out #(
  parameter int LINE_PIXELS   = 64,
  parameter int MONO_LINE_MAX = 1200,
  parameter int PAL_LINES_MIN = 288
) (
  input  logic                 clk32_i,
  input  logic                 rst_n,
  input  cfg_pkg::apb_req_t    apb_req,
  output cfg_pkg::apb_rsp_t    apb_rsp,
  input  video_pkg::sync_t     sync_in,
  input  video_pkg::rgb4_t     pix_in,
  input  video_pkg::stereo18_t audio_in,
  output video_pkg::rgb6_t     pix_out,
  output logic                 out_valid,
  output video_pkg::stereo16_t audio_out,
  output video_pkg::vmode_e    mode,
  output logic                 vreset,
  output logic                 wide
);

  cfg_pkg::av_cfg_t cfg;

  // wide is only passed on to the transmitter
  assign wide = cfg.wide;

  video_cfg_regs video_cfg_regs_inst (
    .clk32_i (clk32_i),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .mode    (mode),
    .cfg     (cfg)
  );

  video_mode_detect #(
    .MONO_LINE_MAX (MONO_LINE_MAX),
    .PAL_LINES_MIN (PAL_LINES_MIN)
  ) video_mode_detect_inst (
    .clk32_i (clk32_i),
    .rst_n   (rst_n),
    .sync_in (sync_in),
    .mode    (mode),
    .vreset  (vreset)
  );

  line_doubler #(
    .LINE_PIXELS (LINE_PIXELS)
  ) line_doubler_inst (
    .clk32_i   (clk32_i),
    .rst_n     (rst_n),
    .sync_in   (sync_in),
    .pix_in    (pix_in),
    .mode      (mode),
    .scanlines (cfg.scanlines),
    .pix_out   (pix_out),
    .out_valid (out_valid)
  );

  audio_level audio_level_inst (
    .clk32_i   (clk32_i),
    .rst_n     (rst_n),
    .audio_in  (audio_in),
    .volume    (cfg.volume),
    .audio_out (audio_out)
  );

endmodule

/* design/video_pkg.sv */
// Video and audio stream types
package video_pkg;

  // input pixel from the core, 4 bits per channel
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb4_t;

  // doubled pixel, wide enough for scanline dimming
  typedef struct packed {
    logic [5:0] r;
    logic [5:0] g;
    logic [5:0] b;
  } rgb6_t;

  // syncs are active low, de marks visible pixels
  typedef struct packed {
    logic hs_n;
    logic vs_n;
    logic de;
  } sync_t;

  typedef enum logic [1:0] {
    VMODE_PAL  = 2'd0,
    VMODE_NTSC = 2'd1,
    VMODE_MONO = 2'd2
  } vmode_e;

  // raw sample pair from the sound chip
  typedef struct packed {
    logic signed [17:0] left;
    logic signed [17:0] right;
  } stereo18_t;

  // sample pair as sent to the transmitter
  typedef struct packed {
    logic signed [15:0] left;
    logic signed [15:0] right;
  } stereo16_t;

endpackage

/* tb.f */
design/video_pkg.sv
design/cfg_pkg.sv
design/video_cfg_regs.sv
design/video_mode_detect.sv
design/line_doubler.sv
design/audio_level.sv
design/video_out.sv
tests/video_out_tb.sv

/* tests/video_out_tb.sv */
// Video output testbench
`timescale 1ns/1ps

module video_out_tb;

  localparam int LINE_PIX   = 16;
  localparam int MONO_MAX   = 40;
  localparam int PAL_MIN    = 6;
  localparam int APB_WAIT   = 16;
  localparam int DRAIN_WAIT = 200;

  logic                 clk32_i;
  logic                 rst_n;
  cfg_pkg::apb_req_t    apb_req;
  cfg_pkg::apb_rsp_t    apb_rsp;
  video_pkg::sync_t     sync_in;
  video_pkg::rgb4_t     pix_in;
  video_pkg::stereo18_t audio_in;
  video_pkg::rgb6_t     pix_out;
  logic                 out_valid;
  video_pkg::stereo16_t audio_out;
  video_pkg::vmode_e    mode;
  logic                 vreset;
  logic                 wide;

  int seed = 3623;
  int cyc = 0;
  int checks = 0;
  int errors = 0;
  int frames = 0;
  int vreset_cnt = 0;
  bit hung = 1'b0;

  // expected outputs and their input cycles (-1 when only order matters)
  video_pkg::rgb6_t     exp_pix[$];
  int                   exp_cyc[$];
  video_pkg::stereo16_t aud_exp[$];
  int                   aud_cyc[$];

  video_out #(
    .LINE_PIXELS   (LINE_PIX),
    .MONO_LINE_MAX (MONO_MAX),
    .PAL_LINES_MIN (PAL_MIN)
  ) video_out_inst (
    .clk32_i   (clk32_i),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .sync_in   (sync_in),
    .pix_in    (pix_in),
    .audio_in  (audio_in),
    .pix_out   (pix_out),
    .out_valid (out_valid),
    .audio_out (audio_out),
    .mode      (mode),
    .vreset    (vreset),
    .wide      (wide)
  );

  initial begin
    clk32_i = 1'b0;
    forever #5 clk32_i = ~clk32_i;
  end

  always @(posedge clk32_i) begin
    cyc <= cyc + 1;
  end

  // 4-bit colour widened by repeating its top bits
  function automatic logic [5:0] widen(input logic [3:0] v);
    int x;
    x = v;
    return 6'(x * 4 + x / 4);
  endfunction

  function automatic logic [5:0] dim_level(input logic [5:0] c, input int level);
    int x;
    x = c;
    case (level)
      1: x = x - x / 4;
      2: x = x / 2;
      3: x = x / 4;
      default: x = x;
    endcase
    return 6'(x);
  endfunction

  function automatic video_pkg::rgb6_t expect_pixel(input video_pkg::rgb4_t p, input int level);
    video_pkg::rgb6_t e;
    e.r = dim_level(widen(p.r), level);
    e.g = dim_level(widen(p.g), level);
    e.b = dim_level(widen(p.b), level);
    return e;
  endfunction

  // divide by 4, then volume as a signed shift
  function automatic logic [15:0] scale_sample(input logic signed [17:0] s, input int vol);
    int x;
    x = s;
    x = x >>> 2;
    case (vol)
      0: x = 0;
      1: x = x >>> 2;
      2: x = x >>> 1;
      default: x = x;
    endcase
    return 16'(x);
  endfunction

  function automatic video_pkg::stereo16_t expect_audio(input video_pkg::stereo18_t s,
                                                         input int vol);
    video_pkg::stereo16_t e;
    e.left  = scale_sample(s.left, vol);
    e.right = scale_sample(s.right, vol);
    return e;
  endfunction

  function automatic video_pkg::vmode_e expect_mode(input int period, input int lines);
    if (period <= MONO_MAX) begin
      return video_pkg::VMODE_MONO;
    end
    return (lines >= PAL_MIN) ? video_pkg::VMODE_PAL : video_pkg::VMODE_NTSC;
  endfunction

  task automatic check_cond(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s", $time, what);
    end
  endtask

  task automatic tick();
    @(posedge clk32_i);
    #1;
  endtask

  task automatic apb_transfer(input bit is_write, input logic [3:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int n;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = is_write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    tick();
    apb_req.penable = 1'b1;
    n = 0;
    @(negedge clk32_i);
    while (!apb_rsp.pready && n < APB_WAIT) begin
      @(negedge clk32_i);
      n++;
    end
    if (!apb_rsp.pready) begin
      hung = 1'b1;
      $display("timeout: APB slave kept pready low for %0d cycles", APB_WAIT);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    tick();
    apb_req = '0;
  endtask

  task automatic drain_queues(input string what);
    int n;
    n = 0;
    while ((exp_pix.size() > 0 || aud_exp.size() > 0) && n < DRAIN_WAIT) begin
      tick();
      n++;
    end
    if (exp_pix.size() > 0 || aud_exp.size() > 0) begin
      hung = 1'b1;
      $display("timeout: %s output stopped with results still pending", what);
    end
  endtask

  // lines start at hs_n falling; a closing line drops hs_n and vs_n together
  task automatic run_frame(input int period, input int lines, input int width,
                           input int level, input bit mono);
    video_pkg::rgb4_t line_q[$];
    logic [31:0]      r;
    for (int l = 0; l <= lines; l++) begin
      line_q.delete();
      for (int t = 0; t < period; t++) begin
        tick();
        sync_in.hs_n = (t >= 4);
        sync_in.vs_n = (l < lines) || (t >= 4);
        sync_in.de   = (l < lines) && (t >= 6) && (t < 6 + width);
        if (sync_in.de) begin
          r = $random(seed);
          pix_in = r[11:0];
          line_q.push_back(pix_in);
          if (mono) begin
            exp_pix.push_back(expect_pixel(pix_in, 0));
            exp_cyc.push_back(cyc);
          end
        end
      end
      // plain copy first, then the dimmed one
      if (!mono) begin
        foreach (line_q[i]) begin
          exp_pix.push_back(expect_pixel(line_q[i], 0));
          exp_cyc.push_back(-1);
        end
        foreach (line_q[i]) begin
          exp_pix.push_back(expect_pixel(line_q[i], level));
          exp_cyc.push_back(-1);
        end
      end
    end
    frames++;
  endtask

  task automatic reg_access();
    cfg_pkg::ctrl_word_u w;
    logic [31:0]         rd;
    logic                err;
    apb_transfer(1'b0, cfg_pkg::ADDR_VIDEO_CTRL, '0, rd, err);
    check_cond(rd == '0 && !err, "video control not zero after reset");
    apb_transfer(1'b0, cfg_pkg::ADDR_AUDIO_CTRL, '0, rd, err);
    check_cond(rd == '0 && !err, "audio control not zero after reset");
    check_cond(wide == 1'b0, "wide set after reset");
    w = '0;
    w.video.scanlines = 2'd2;
    w.video.wide      = 1'b1;
    apb_transfer(1'b1, cfg_pkg::ADDR_VIDEO_CTRL, w, rd, err);
    check_cond(!err && wide == 1'b1, "wide output does not follow the register");
    w = '0;
    w.audio.volume = 2'd1;
    apb_transfer(1'b1, cfg_pkg::ADDR_AUDIO_CTRL, w, rd, err);
    apb_transfer(1'b1, 4'hC, '1, rd, err);
    check_cond(err, "no slave error on unmapped write");
    // unmapped write must leave both registers alone
    apb_transfer(1'b0, cfg_pkg::ADDR_VIDEO_CTRL, '0, rd, err);
    w = rd;
    check_cond(w.video.scanlines == 2'd2 && w.video.wide, $sformatf("video read %h", rd));
    apb_transfer(1'b0, cfg_pkg::ADDR_AUDIO_CTRL, '0, rd, err);
    w = rd;
    check_cond(w.audio.volume == 2'd1 && !err, $sformatf("audio read %h", rd));
    apb_transfer(1'b1, cfg_pkg::ADDR_VIDEO_CTRL, '0, rd, err);
  endtask

  task automatic audio_levels();
    cfg_pkg::ctrl_word_u w;
    logic [31:0]         rd;
    logic [31:0]         r1;
    logic [31:0]         r2;
    logic                err;
    for (int v = 0; v < 4; v++) begin
      w = '0;
      w.audio.volume = 2'(v);
      apb_transfer(1'b1, cfg_pkg::ADDR_AUDIO_CTRL, w, rd, err);
      repeat (24) begin
        tick();
        r1 = $random(seed);
        r2 = $random(seed);
        audio_in = {r1, r2[3:0]};
        aud_exp.push_back(expect_audio(audio_in, v));
        aud_cyc.push_back(cyc);
      end
      drain_queues("audio");
    end
  endtask

  task automatic line_doubling();
    cfg_pkg::ctrl_word_u w;
    logic [31:0]         rd;
    logic                err;
    for (int s = 0; s < 4; s++) begin
      w = '0;
      w.video.scanlines = 2'(s);
      apb_transfer(1'b1, cfg_pkg::ADDR_VIDEO_CTRL, w, rd, err);
      run_frame(48, PAL_MIN, (s % 2 == 0) ? LINE_PIX : LINE_PIX - 5, s, 1'b0);
      drain_queues("line doubler");
    end
    check_cond(mode == video_pkg::VMODE_PAL, "mode left PAL during doubling");
  endtask

  task automatic verify_mode(input int period, input int lines);
    video_pkg::vmode_e exp_m;
    logic [31:0]       rd;
    logic              err;
    run_frame(period, lines, 0, 0, 1'b0);
    exp_m = expect_mode(period, lines);
    check_cond(mode == exp_m, $sformatf("mode port %0d expected %0d", mode, exp_m));
    apb_transfer(1'b0, cfg_pkg::ADDR_STATUS, '0, rd, err);
    check_cond(rd[1:0] == exp_m && !err, $sformatf("status %h expected %0d", rd, exp_m));
  endtask

  task automatic mode_classes();
    verify_mode(48, PAL_MIN - 2);
    verify_mode(48, PAL_MIN);
    verify_mode(24, 4);
    check_cond(vreset_cnt == frames,
               $sformatf("%0d vreset cycles for %0d frames", vreset_cnt, frames));
  endtask

  task automatic mono_bypass();
    cfg_pkg::ctrl_word_u w;
    logic [31:0]         rd;
    logic                err;
    w = '0;
    w.video.scanlines = 2'd3;
    apb_transfer(1'b1, cfg_pkg::ADDR_VIDEO_CTRL, w, rd, err);
    run_frame(24, 3, LINE_PIX, 3, 1'b1);
    drain_queues("mono");
    check_cond(mode == video_pkg::VMODE_MONO, "mode left mono");
  endtask

  task automatic report(input string name, input int err_start);
    $display("test %s finished, %0d errors%s", name, errors - err_start,
             hung ? ", stopped by timeout" : "");
  endtask

  // outputs compared on the falling edge
  always @(negedge clk32_i) begin
    if (rst_n) begin
      if (vreset) begin
        vreset_cnt++;
      end
      if (out_valid) begin
        check_cond(exp_pix.size() > 0, "output pixel with nothing expected");
        if (exp_pix.size() > 0) begin
          check_cond(pix_out == exp_pix[0],
                     $sformatf("pixel %h expected %h", pix_out, exp_pix[0]));
          if (exp_cyc[0] >= 0) begin
            check_cond(cyc == exp_cyc[0] + 1, "mono pixel not 1 cycle after its de");
          end
          void'(exp_pix.pop_front());
          void'(exp_cyc.pop_front());
        end
      end
      if (aud_cyc.size() > 0 && cyc >= aud_cyc[0] + 2) begin
        check_cond(audio_out == aud_exp[0],
                   $sformatf("audio %h expected %h", audio_out, aud_exp[0]));
        void'(aud_exp.pop_front());
        void'(aud_cyc.pop_front());
      end
    end
  end

  initial begin
    int e0;
    rst_n    = 1'b0;
    apb_req  = '0;
    sync_in  = '{hs_n: 1'b1, vs_n: 1'b1, de: 1'b0};
    pix_in   = '0;
    audio_in = '0;
    repeat (8) @(posedge clk32_i);
    #1;
    rst_n = 1'b1;
    e0 = errors;
    reg_access();
    report("registers", e0);
    if (!hung) begin
      e0 = errors;
      audio_levels();
      report("audio", e0);
    end
    if (!hung) begin
      e0 = errors;
      line_doubling();
      report("line doubling", e0);
    end
    if (!hung) begin
      e0 = errors;
      mode_classes();
      report("mode detection", e0);
    end
    if (!hung) begin
      e0 = errors;
      mono_bypass();
      report("mono bypass", e0);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && !hung) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
